/* list.f */
+incdir+include
src/ldu_dq_pkg.sv
src/dispatch_alloc.sv
src/wakeup_kill_check.sv
src/dq_entry_array.sv
src/launch_ctrl.sv
src/ldu_dq.sv
sim/tb_ldu_dq.sv

/* Makefile */
VERILATOR ?= verilator
TOP       := tb_ldu_dq
FILELIST  := list.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing --assert -Wno-fatal
LINTFLAGS := --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)

/* sim/tb_ldu_dq.sv */
// testbench for the load unit dispatch queue
// directed and random dispatch checked against an in-order reference queue
`default_nettype none

`include "ldu_dq_defs.svh"

module tb_ldu_dq
    import ldu_dq_pkg::*;
();

    localparam int TIMEOUT_CYCLES = 200;
    localparam int RANDOM_CYCLES = 400;

    logic                           CLK;
    logic                           nRST;
    logic [`DISPATCH_WAYS-1:0]      dispatch_attempt;
    logic [`DISPATCH_WAYS-1:0]      dispatch_valid;
    dq_op_t [`DISPATCH_WAYS-1:0]    dispatch_op;
    logic [`DISPATCH_WAYS-1:0]      dispatch_ack;
    wb_bus_t                        wb_bus;
    rob_kill_t                      rob_kill;
    logic                           cq_enq_valid;
    cq_enq_t                        cq_enq;
    logic                           cq_enq_ready;
    logic [`LOG_LDU_CQ_ENTRIES-1:0] cq_enq_index;
    logic                           iq_enq_valid;
    iq_enq_t                        iq_enq;
    logic                           iq_enq_ready;

    integer seed = 32'h9364ce6a;

    // reference queue, oldest at index 0
    dq_op_t model_op [`LDU_DQ_ENTRIES];
    logic   model_killed [`LDU_DQ_ENTRIES];
    int     model_count;

    // launches seen on the cq outputs
    int     launch_count;
    int     killed_launch_count;

    ldu_dq UUT (.*);

    always #50 CLK = ~CLK;

    // ------------------------------------------------
    // helpers

    task automatic check_value(string name, logic [63:0] got, logic [63:0] expected);
        if (got !== expected) begin
            $display("MISMATCH time=%0t signal=%s got=%0h expected=%0h",
                $time, name, got, expected);
            $display("STATUS: FAIL");
            $fatal(1, "value check failed");
        end
    endtask

    task automatic report_failure(string what);
        $display("ERROR at time %0t: %s", $time, what);
        $display("STATUS: FAIL");
        $fatal(1, "run stopped on error");
    endtask

    function automatic int rand_below(int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic dq_op_t random_op(logic [`LOG_ROB_ENTRIES-1:0] rob);
        dq_op_t op;
        op.op = ldu_op_e'(4'(rand_below(7)));
        op.imm12 = $random(seed);
        op.a_pr = $random(seed);
        op.a_ready = rand_below(2) == 0;
        op.a_is_zero = rand_below(8) == 0;
        op.dest_pr = $random(seed);
        op.rob_index = rob;
        return op;
    endfunction

    // ways in order, each takes one of the slots still free
    function automatic logic [`DISPATCH_WAYS-1:0] expected_ack(
        logic [`DISPATCH_WAYS-1:0] attempt, int free_count);
        logic [`DISPATCH_WAYS-1:0] ack;
        int left;
        ack = '0;
        left = free_count;
        for (int w = 0; w < `DISPATCH_WAYS; w++) begin
            if (attempt[w] && left > 0) begin
                ack[w] = 1'b1;
                left--;
            end
        end
        return ack;
    endfunction

    // bank is the low tag bits, the rest must match that bank's tag
    function automatic logic wb_hit(logic [`LOG_PR_COUNT-1:0] pr);
        int bank;
        bank = pr % `PRF_BANK_COUNT;
        return wb_bus.valid[bank] && (wb_bus.upper_pr[bank] == pr / `PRF_BANK_COUNT);
    endfunction

    function automatic logic kill_hit(logic [`LOG_ROB_ENTRIES-1:0] rob);
        int age;
        age = (int'(rob) - int'(rob_kill.abs_head_index) + (1 << `LOG_ROB_ENTRIES))
            % (1 << `LOG_ROB_ENTRIES);
        return rob_kill.valid && (age > int'(rob_kill.rel_kill_younger_index));
    endfunction

    task automatic next_cycle();
        @(posedge CLK);
        #10;
    endtask

    task automatic drain_queue();
        int n;
        n = 0;
        while (model_count != 0 && n < TIMEOUT_CYCLES) begin
            next_cycle();
            n++;
        end
        if (model_count != 0) begin
            report_failure("queue did not drain before the timeout");
        end
    endtask

    // ------------------------------------------------
    // compare against the model, then advance it to the next edge

    always @(negedge CLK) begin
        logic [`DISPATCH_WAYS-1:0] exp_ack;
        dq_op_t head_op;
        logic head_killed;
        logic exp_launch;
        if (!nRST) begin
            model_count = 0;
        end
        else begin
            exp_ack = expected_ack(dispatch_attempt, `LDU_DQ_ENTRIES - model_count);
            check_value("dispatch_ack", dispatch_ack, exp_ack);
            exp_launch = 1'b0;
            head_killed = 1'b0;
            head_op = model_op[0];
            if (model_count > 0) begin
                head_op.a_ready = head_op.a_ready | wb_hit(head_op.a_pr);
                head_killed = model_killed[0] | kill_hit(head_op.rob_index);
                exp_launch = cq_enq_ready && (iq_enq_ready || head_killed);
            end
            check_value("cq_enq_valid", cq_enq_valid, exp_launch);
            check_value("iq_enq_valid", iq_enq_valid, exp_launch && !head_killed);
            if (exp_launch) begin
                check_value("cq_enq.killed", cq_enq.killed, head_killed);
                check_value("cq_enq.op", cq_enq.op, head_op.op);
                check_value("cq_enq.dest_pr", cq_enq.dest_pr, head_op.dest_pr);
                check_value("cq_enq.rob_index", cq_enq.rob_index, head_op.rob_index);
            end
            if (cq_enq_valid) begin
                launch_count++;
                if (cq_enq.killed) begin
                    killed_launch_count++;
                end
            end
            if (exp_launch && !head_killed) begin
                check_value("iq_enq.op", iq_enq.op, head_op.op);
                check_value("iq_enq.imm12", iq_enq.imm12, head_op.imm12);
                check_value("iq_enq.a_pr", iq_enq.a_pr, head_op.a_pr);
                check_value("iq_enq.a_ready", iq_enq.a_ready, head_op.a_ready);
                check_value("iq_enq.a_is_zero", iq_enq.a_is_zero, head_op.a_is_zero);
                check_value("iq_enq.cq_index", iq_enq.cq_index, cq_enq_index);
            end

            // wakeup and kill stick to waiting ops
            for (int i = 0; i < model_count; i++) begin
                model_op[i].a_ready |= wb_hit(model_op[i].a_pr);
                model_killed[i] |= kill_hit(model_op[i].rob_index);
            end
            if (exp_launch) begin
                for (int i = 0; i < `LDU_DQ_ENTRIES - 1; i++) begin
                    model_op[i] = model_op[i+1];
                    model_killed[i] = model_killed[i+1];
                end
                model_count--;
            end
            // acked ways with valid low leave no op behind
            for (int w = 0; w < `DISPATCH_WAYS; w++) begin
                if (exp_ack[w] && dispatch_valid[w] && model_count < `LDU_DQ_ENTRIES) begin
                    model_op[model_count] = dispatch_op[w];
                    model_killed[model_count] = 1'b0;
                    model_count++;
                end
            end
        end
    end

    // ------------------------------------------------
    // stimulus

    initial begin
        logic chain;
        int base_killed;
        int base_launch;
        CLK = 1'b0;
        nRST = 1'b0;
        dispatch_attempt = '0;
        dispatch_valid = '0;
        dispatch_op = '0;
        wb_bus = '0;
        rob_kill = '0;
        cq_enq_ready = 1'b0;
        cq_enq_index = '0;
        iq_enq_ready = 1'b0;
        launch_count = 0;
        killed_launch_count = 0;
        repeat (2) @(posedge CLK);
        #10;
        nRST = 1'b1;

        // empty after reset, then fill all four slots
        @(negedge CLK);
        check_value("cq_enq_valid", cq_enq_valid, 1'b0);
        check_value("iq_enq_valid", iq_enq_valid, 1'b0);
        next_cycle();
        for (int w = 0; w < `DISPATCH_WAYS; w++) begin
            dispatch_op[w] = random_op(6'(w));
        end
        dispatch_attempt = '1;
        dispatch_valid = '1;
        @(negedge CLK);
        check_value("dispatch_ack", dispatch_ack, 4'hf);
        next_cycle();
        dispatch_attempt = 4'b0001;
        @(negedge CLK);
        check_value("dispatch_ack", dispatch_ack, 4'h0);
        next_cycle();
        dispatch_attempt = '0;
        cq_enq_ready = 1'b1;
        iq_enq_ready = 1'b1;
        cq_enq_index = 4'h5;
        drain_queue();
        check_value("launch_count", launch_count, 4);

        // random mixes, valid-low ways only after the valid ones
        for (int c = 0; c < RANDOM_CYCLES; c++) begin
            chain = 1'b1;
            for (int w = 0; w < `DISPATCH_WAYS; w++) begin
                dispatch_attempt[w] = rand_below(2) == 0;
                dispatch_op[w] = random_op(6'(rand_below(64)));
                dispatch_valid[w] = dispatch_attempt[w] && chain && rand_below(4) != 0;
                if (dispatch_attempt[w] && !dispatch_valid[w]) begin
                    chain = 1'b0;
                end
            end
            wb_bus = $random(seed);
            rob_kill = $random(seed);
            rob_kill.valid = rand_below(6) == 0;
            cq_enq_ready = rand_below(4) != 0;
            iq_enq_ready = rand_below(4) != 0;
            cq_enq_index = $random(seed);
            next_cycle();
        end
        dispatch_attempt = '0;
        wb_bus = '0;
        rob_kill = '0;
        cq_enq_ready = 1'b1;
        iq_enq_ready = 1'b1;
        drain_queue();

        // wrapping rob indices 62 63 0 1, the head waits on tag 0x25
        for (int w = 0; w < `DISPATCH_WAYS; w++) begin
            dispatch_op[w] = random_op(6'(62 + w));
            dispatch_op[w].a_ready = 1'b0;
        end
        dispatch_op[0].a_pr = 7'h25;
        dispatch_attempt = '1;
        dispatch_valid = '1;
        cq_enq_ready = 1'b0;
        next_cycle();
        dispatch_attempt = '0;
        wb_bus.valid = 4'b0010;
        wb_bus.upper_pr[1] = 5'h09;
        repeat (3) next_cycle();
        wb_bus = '0;
        // head 61 with window 2 kills rob 0 and 1 only
        rob_kill = '{valid: 1'b1, abs_head_index: 6'd61, rel_kill_younger_index: 6'd2};
        next_cycle();
        rob_kill = '0;
        base_killed = killed_launch_count;
        base_launch = launch_count;
        cq_enq_ready = 1'b1;
        iq_enq_ready = 1'b0;
        repeat (3) next_cycle();
        check_value("launch_count", launch_count - base_launch, 0);
        iq_enq_ready = 1'b1;
        drain_queue();
        check_value("launch_count", launch_count - base_launch, 4);
        check_value("killed_launch_count", killed_launch_count - base_killed, 2);

        // killed heads go with iq ready low
        for (int w = 0; w < `DISPATCH_WAYS; w++) begin
            dispatch_op[w] = random_op(6'(10 + w));
        end
        dispatch_attempt = '1;
        cq_enq_ready = 1'b0;
        next_cycle();
        dispatch_attempt = '0;
        rob_kill = '{valid: 1'b1, abs_head_index: 6'd0, rel_kill_younger_index: 6'd5};
        next_cycle();
        rob_kill = '0;
        base_killed = killed_launch_count;
        cq_enq_ready = 1'b1;
        iq_enq_ready = 1'b0;
        drain_queue();
        check_value("killed_launch_count", killed_launch_count - base_killed, 4);

        $display("STATUS: PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* src/ldu_dq.sv */
// load unit dispatch queue
// four-way dispatch into a compacting queue with wakeup, kill and
// launch into the central and issue queues
`default_nettype none

`include "ldu_dq_defs.svh"

module ldu_dq
    import ldu_dq_pkg::*;
(
    input  logic                                CLK,
    input  logic                                nRST,

    // dispatch by way
    input  logic [`DISPATCH_WAYS-1:0]           dispatch_attempt,
    input  logic [`DISPATCH_WAYS-1:0]           dispatch_valid,
    input  dq_op_t [`DISPATCH_WAYS-1:0]         dispatch_op,
    output logic [`DISPATCH_WAYS-1:0]           dispatch_ack,

    // writeback and kill
    input  wb_bus_t                             wb_bus,
    input  rob_kill_t                           rob_kill,

    // central queue enqueue
    output logic                                cq_enq_valid,
    output cq_enq_t                             cq_enq,
    input  logic                                cq_enq_ready,
    input  logic [`LOG_LDU_CQ_ENTRIES-1:0]      cq_enq_index,

    // issue queue enqueue
    output logic                                iq_enq_valid,
    output iq_enq_t                             iq_enq,
    input  logic                                iq_enq_ready
);

    dq_entry_t [`LDU_DQ_ENTRIES-1:0]    entries;
    dq_entry_t                          head;
    logic [`LDU_DQ_ENTRIES-1:0]         valid_by_entry;
    logic [`LDU_DQ_ENTRIES-1:0]         fill_by_entry;
    dq_op_t [`LDU_DQ_ENTRIES-1:0]       fill_op_by_entry;
    logic [`LDU_DQ_ENTRIES-1:0]         new_ready;
    logic [`LDU_DQ_ENTRIES-1:0]         new_killed;
    logic                               launching;

    for (genvar i = 0; i < `LDU_DQ_ENTRIES; i++) begin : g_valid
        assign valid_by_entry[i] = entries[i].valid;
    end

    dispatch_alloc u_alloc (
        .dispatch_attempt   (dispatch_attempt),
        .dispatch_valid     (dispatch_valid),
        .dispatch_op        (dispatch_op),
        .valid_by_entry     (valid_by_entry),
        .dispatch_ack       (dispatch_ack),
        .fill_by_entry      (fill_by_entry),
        .fill_op_by_entry   (fill_op_by_entry)
    );

    dq_entry_array u_entries (
        .CLK                (CLK),
        .nRST               (nRST),
        .launching          (launching),
        .fill_by_entry      (fill_by_entry),
        .fill_op_by_entry   (fill_op_by_entry),
        .new_ready          (new_ready),
        .new_killed         (new_killed),
        .entries            (entries),
        .head               (head)
    );

    wakeup_kill_check u_check (
        .entries            (entries),
        .wb_bus             (wb_bus),
        .rob_kill           (rob_kill),
        .new_ready          (new_ready),
        .new_killed         (new_killed)
    );

    launch_ctrl u_launch (
        .head               (head),
        .cq_enq_ready       (cq_enq_ready),
        .cq_enq_index       (cq_enq_index),
        .iq_enq_ready       (iq_enq_ready),
        .launching          (launching),
        .cq_enq_valid       (cq_enq_valid),
        .cq_enq             (cq_enq),
        .iq_enq_valid       (iq_enq_valid),
        .iq_enq             (iq_enq)
    );

endmodule

`default_nettype wire

/* src/launch_ctrl.sv */
// launch control
// decides when the head leaves and splits it into cq and iq enqueues
`default_nettype none

`include "ldu_dq_defs.svh"

module launch_ctrl
    import ldu_dq_pkg::*;
(
    input  dq_entry_t                           head,
    input  logic                                cq_enq_ready,
    input  logic [`LOG_LDU_CQ_ENTRIES-1:0]      cq_enq_index,
    input  logic                                iq_enq_ready,
    output logic                                launching,
    output logic                                cq_enq_valid,
    output cq_enq_t                             cq_enq,
    output logic                                iq_enq_valid,
    output iq_enq_t                             iq_enq
);

    always_comb begin
        // a killed head only needs the central queue
        launching = head.valid & cq_enq_ready & (iq_enq_ready | head.killed);

        cq_enq_valid = launching;
        iq_enq_valid = launching & ~head.killed;

        // ------------------------------------------------
        // central queue payload
        cq_enq.killed = head.killed;
        cq_enq.op = head.payload.op;
        cq_enq.dest_pr = head.payload.dest_pr;
        cq_enq.rob_index = head.payload.rob_index;

        // ------------------------------------------------
        // issue queue payload, tagged with the cq slot
        iq_enq.op = head.payload.op;
        iq_enq.imm12 = head.payload.imm12;
        iq_enq.a_pr = head.payload.a_pr;
        iq_enq.a_ready = head.payload.a_ready;
        iq_enq.a_is_zero = head.payload.a_is_zero;
        iq_enq.cq_index = cq_enq_index;

        // kill marks only ever sit on a stored op
        assert (head.valid || !head.killed)
            else $error("launch_ctrl: killed flag on an empty head");
    end

endmodule

`default_nettype wire

/* src/dq_entry_array.sv */
// dispatch queue entry storage
// compacting queue with the oldest op at entry 0; shifts down on launch,
// fills empty slots from dispatch and keeps wakeup and kill sticky
`default_nettype none

`include "ldu_dq_defs.svh"

module dq_entry_array
    import ldu_dq_pkg::*;
(
    input  logic                                CLK,
    input  logic                                nRST,
    input  logic                                launching,
    input  logic [`LDU_DQ_ENTRIES-1:0]          fill_by_entry,
    input  dq_op_t [`LDU_DQ_ENTRIES-1:0]        fill_op_by_entry,
    input  logic [`LDU_DQ_ENTRIES-1:0]          new_ready,
    input  logic [`LDU_DQ_ENTRIES-1:0]          new_killed,
    output dq_entry_t [`LDU_DQ_ENTRIES-1:0]     entries,
    output dq_entry_t                           head
);

    // stored state
    logic [`LDU_DQ_ENTRIES-1:0]     valid_q;
    logic [`LDU_DQ_ENTRIES-1:0]     killed_q;
    dq_op_t [`LDU_DQ_ENTRIES-1:0]   payload_q;

    // candidates for the next cycle
    dq_entry_t [`LDU_DQ_ENTRIES-1:0] merged;
    dq_entry_t [`LDU_DQ_ENTRIES-1:0] fill_entry;
    dq_entry_t [`LDU_DQ_ENTRIES-1:0] next_entry;

    logic compacted;

    // ------------------------------------------------
    // current view with same-cycle wakeup and kill

    always_comb begin
        for (int i = 0; i < `LDU_DQ_ENTRIES; i++) begin
            entries[i].valid = valid_q[i];
            entries[i].killed = killed_q[i];
            entries[i].payload = payload_q[i];

            merged[i].valid = valid_q[i];
            merged[i].killed = killed_q[i] | new_killed[i];
            merged[i].payload = payload_q[i];
            merged[i].payload.a_ready = payload_q[i].a_ready | new_ready[i];

            // a fresh op starts live
            fill_entry[i].valid = fill_by_entry[i];
            fill_entry[i].killed = 1'b0;
            fill_entry[i].payload = fill_op_by_entry[i];
        end
    end

    assign head = merged[0];

    // ------------------------------------------------
    // next entry select

    always_comb begin
        // lower entries take self or the slot above
        for (int i = 0; i < `LDU_DQ_ENTRIES - 1; i++) begin
            if (launching) begin
                next_entry[i] = valid_q[i+1] ? merged[i+1] : fill_entry[i+1];
            end
            else begin
                next_entry[i] = valid_q[i] ? merged[i] : fill_entry[i];
            end
        end

        // top entry has nothing above, so it empties on launch
        if (launching) begin
            next_entry[`LDU_DQ_ENTRIES-1] = merged[`LDU_DQ_ENTRIES-1];
            next_entry[`LDU_DQ_ENTRIES-1].valid = 1'b0;
            next_entry[`LDU_DQ_ENTRIES-1].killed = 1'b0;
        end
        else if (valid_q[`LDU_DQ_ENTRIES-1]) begin
            next_entry[`LDU_DQ_ENTRIES-1] = merged[`LDU_DQ_ENTRIES-1];
        end
        else begin
            next_entry[`LDU_DQ_ENTRIES-1] = fill_entry[`LDU_DQ_ENTRIES-1];
        end
    end

    // ------------------------------------------------
    // registers

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            valid_q <= '0;
            killed_q <= '0;
        end
        else begin
            for (int i = 0; i < `LDU_DQ_ENTRIES; i++) begin
                valid_q[i] <= next_entry[i].valid;
                killed_q[i] <= next_entry[i].killed;
            end
        end
    end

    always_ff @(posedge CLK) begin
        for (int i = 0; i < `LDU_DQ_ENTRIES; i++) begin
            payload_q[i] <= next_entry[i].payload;
        end
    end

    // no gap below a valid entry, else the head order breaks
    always_comb begin
        compacted = 1'b1;
        for (int i = 0; i < `LDU_DQ_ENTRIES - 1; i++) begin
            if (valid_q[i+1] && !valid_q[i]) begin
                compacted = 1'b0;
            end
        end
    end

    assert property (@(posedge CLK) disable iff (!nRST) compacted)
        else $error("dq_entry_array: valid entry above an empty one");

endmodule

`default_nettype wire

/* src/wakeup_kill_check.sv */
// wakeup and kill check
// compares every stored op against the writeback tags and the rob kill window
`default_nettype none

`include "ldu_dq_defs.svh"

module wakeup_kill_check
    import ldu_dq_pkg::*;
(
    input  dq_entry_t [`LDU_DQ_ENTRIES-1:0]    entries,
    input  wb_bus_t                             wb_bus,
    input  rob_kill_t                           rob_kill,
    output logic [`LDU_DQ_ENTRIES-1:0]         new_ready,
    output logic [`LDU_DQ_ENTRIES-1:0]         new_killed
);

    always_comb begin
        logic [`LOG_PRF_BANK_COUNT-1:0] bank;
        logic [`UPPER_PR_WIDTH-1:0]     upper;
        logic [`LOG_ROB_ENTRIES-1:0]    age;

        for (int i = 0; i < `LDU_DQ_ENTRIES; i++) begin
            // tag splits into bank select and upper bits
            bank = entries[i].payload.a_pr[`LOG_PRF_BANK_COUNT-1:0];
            upper = entries[i].payload.a_pr[`LOG_PR_COUNT-1:`LOG_PRF_BANK_COUNT];

            new_ready[i] = entries[i].valid
                & wb_bus.valid[bank]
                & (wb_bus.upper_pr[bank] == upper);

            // distance from rob head, wraps modulo rob size
            age = entries[i].payload.rob_index - rob_kill.abs_head_index;

            new_killed[i] = entries[i].valid
                & rob_kill.valid
                & (age > rob_kill.rel_kill_younger_index);
        end
    end

endmodule

`default_nettype wire

/* src/dispatch_alloc.sv */
// dispatch allocator
// hands each attempting way the lowest free entry left by earlier ways
// and steers the way payloads onto their entry slots
`default_nettype none

`include "ldu_dq_defs.svh"

module dispatch_alloc
    import ldu_dq_pkg::*;
(
    input  logic [`DISPATCH_WAYS-1:0]           dispatch_attempt,
    input  logic [`DISPATCH_WAYS-1:0]           dispatch_valid,
    input  dq_op_t [`DISPATCH_WAYS-1:0]         dispatch_op,
    input  logic [`LDU_DQ_ENTRIES-1:0]          valid_by_entry,
    output logic [`DISPATCH_WAYS-1:0]           dispatch_ack,
    output logic [`LDU_DQ_ENTRIES-1:0]          fill_by_entry,
    output dq_op_t [`LDU_DQ_ENTRIES-1:0]        fill_op_by_entry
);

    // one-hot entry granted to each way, zero if none
    logic [`DISPATCH_WAYS-1:0][`LDU_DQ_ENTRIES-1:0] grant_by_way;

    // ------------------------------------------------
    // priority pick

    always_comb begin
        logic [`LDU_DQ_ENTRIES-1:0] open_mask;
        logic [`LDU_DQ_ENTRIES-1:0] lowest_open;

        // free before this cycle's launch only
        open_mask = ~valid_by_entry;

        for (int way = 0; way < `DISPATCH_WAYS; way++) begin
            // isolate lowest set bit of the open mask
            lowest_open = open_mask & (~open_mask + 1'b1);
            grant_by_way[way] = lowest_open & {`LDU_DQ_ENTRIES{dispatch_attempt[way]}};
            dispatch_ack[way] = dispatch_attempt[way] & (|open_mask);

            // later ways see what is left
            open_mask = open_mask & ~grant_by_way[way];
        end
    end

    // ------------------------------------------------
    // grant checks

    always_comb begin
        logic [`DISPATCH_WAYS-1:0] ways_on_entry;

        for (int entry = 0; entry < `LDU_DQ_ENTRIES; entry++) begin
            for (int way = 0; way < `DISPATCH_WAYS; way++) begin
                ways_on_entry[way] = grant_by_way[way][entry];
            end

            // two ways landing in one slot would drop an op
            assert ($onehot0(ways_on_entry))
                else $error("dispatch_alloc: grants of two ways share an entry");

            // an occupied slot is never handed out
            assert (!(|ways_on_entry) || !valid_by_entry[entry])
                else $error("dispatch_alloc: grant to an occupied entry");
        end
    end

    // ------------------------------------------------
    // way to entry routing

    // grants are one-hot per entry, so an OR mux is enough
    always_comb begin
        fill_by_entry = '0;
        fill_op_by_entry = '0;

        for (int entry = 0; entry < `LDU_DQ_ENTRIES; entry++) begin
            for (int way = 0; way < `DISPATCH_WAYS; way++) begin
                if (grant_by_way[way][entry]) begin
                    // valid low keeps the slot empty
                    fill_by_entry[entry] = fill_by_entry[entry] | dispatch_valid[way];
                    fill_op_by_entry[entry] =
                        dq_op_t'(fill_op_by_entry[entry] | dispatch_op[way]);
                end
            end
        end
    end

endmodule

`default_nettype wire

/* src/ldu_dq_pkg.sv */
// load unit dispatch queue types
// opcode encoding and the packed payloads passed between the blocks
`default_nettype none

`include "ldu_dq_defs.svh"

package ldu_dq_pkg;

    // load opcodes, funct3 style encoding
    typedef enum logic [3:0] {
        LDU_LB  = 4'b0000,
        LDU_LH  = 4'b0001,
        LDU_LW  = 4'b0010,
        LDU_LD  = 4'b0011,
        LDU_LBU = 4'b0100,
        LDU_LHU = 4'b0101,
        LDU_LWU = 4'b0110
    } ldu_op_e;

    // op as it arrives from dispatch
    typedef struct packed {
        ldu_op_e                        op;
        logic [`IMM_WIDTH-1:0]          imm12;
        logic [`LOG_PR_COUNT-1:0]       a_pr;
        logic                           a_ready;
        logic                           a_is_zero;
        logic [`LOG_PR_COUNT-1:0]       dest_pr;
        logic [`LOG_ROB_ENTRIES-1:0]    rob_index;
    } dq_op_t;

    // one queue slot
    typedef struct packed {
        logic   valid;
        logic   killed;
        dq_op_t payload;
    } dq_entry_t;

    // writeback tags, one lane per register bank
    typedef struct packed {
        logic [`PRF_BANK_COUNT-1:0]                         valid;
        logic [`PRF_BANK_COUNT-1:0][`UPPER_PR_WIDTH-1:0]    upper_pr;
    } wb_bus_t;

    // kill everything younger than head + rel index
    typedef struct packed {
        logic                           valid;
        logic [`LOG_ROB_ENTRIES-1:0]    abs_head_index;
        logic [`LOG_ROB_ENTRIES-1:0]    rel_kill_younger_index;
    } rob_kill_t;

    // central queue side of a launch
    typedef struct packed {
        logic                           killed;
        ldu_op_e                        op;
        logic [`LOG_PR_COUNT-1:0]       dest_pr;
        logic [`LOG_ROB_ENTRIES-1:0]    rob_index;
    } cq_enq_t;

    // issue queue side of a launch
    typedef struct packed {
        ldu_op_e                        op;
        logic [`IMM_WIDTH-1:0]          imm12;
        logic [`LOG_PR_COUNT-1:0]       a_pr;
        logic                           a_ready;
        logic                           a_is_zero;
        logic [`LOG_LDU_CQ_ENTRIES-1:0] cq_index;
    } iq_enq_t;

endpackage

`default_nettype wire

/* include/ldu_dq_defs.svh */
// load unit dispatch queue sizing
// queue depth, dispatch width and the field widths shared by all blocks
`ifndef LDU_DQ_DEFS_SVH
`define LDU_DQ_DEFS_SVH

// queue shape
`define LDU_DQ_ENTRIES 4
`define DISPATCH_WAYS 4

// physical register tags
`define LOG_PR_COUNT 7

// bank select is the low bits of a tag
`define LOG_PRF_BANK_COUNT 2
`define PRF_BANK_COUNT (1 << `LOG_PRF_BANK_COUNT)
`define UPPER_PR_WIDTH (`LOG_PR_COUNT - `LOG_PRF_BANK_COUNT)

// reorder buffer index, wraps modulo its size
`define LOG_ROB_ENTRIES 6

// central queue index returned on enqueue
`define LOG_LDU_CQ_ENTRIES 4

// load immediate
`define IMM_WIDTH 12

`endif
